// File: flist.f
hw/mem_pkg.sv
hw/req_queue.sv
hw/lsu_axil_master.sv
hw/axil_sram.sv
hw/mem_subsys.sv
tests/mem_subsys_props.sv
tests/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - hw/mem_pkg.sv
  - hw/req_queue.sv
  - hw/lsu_axil_master.sv
  - hw/axil_sram.sv
  - hw/mem_subsys.sv
  - target: test
    files:
      - tests/mem_subsys_props.sv
      - tests/tb_mem_subsys.sv

// File: tests/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    mem_req_t req;
    logic     rsp_valid;
    mem_rsp_t rsp;
    logic     overflow;

    logic [data_w-1:0] shadow [mem_words];  // expected SRAM contents
    mem_rsp_t          exp_q [$];
    logic              check_en;
    int                rsp_count;

    mem_subsys i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // strobed bytes merge into the word at addr[9:2]
    function automatic mem_rsp_t ref_access(input mem_req_t r);
        mem_rsp_t   exp;
        logic [7:0] idx;
        idx = r.addr[9:2];
        exp.op = r.op;
        exp.rdata = '0;
        if (r.op == op_load) begin
            exp.rdata = shadow[idx];
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (r.wstrb[b])
                    shadow[idx][b*8 +: 8] = r.wdata[b*8 +: 8];
            end
        end
        return exp;
    endfunction

    task automatic apply_reset();
        rst_n = 1'b0;
        req_valid = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < mem_words; i++)
            shadow[i] = '0;
        exp_q.delete();
    endtask

    // one strobe followed by 6 to 12 idle cycles
    task automatic send_req(input mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb);
        mem_req_t r;
        int       gap;
        r.op = op;
        r.addr = addr;
        r.wdata = wdata;
        r.wstrb = wstrb;
        gap = $urandom_range(12, 6);
        @(posedge clk);
        #1;
        req = r;
        req_valid = 1'b1;
        if (check_en)
            exp_q.push_back(ref_access(r));
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        repeat (gap - 1) @(posedge clk);  // next call waits one more edge
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 200)
                abort_run("timeout: a response did not arrive within 200 cycles");
        end
    endtask

    always @(negedge clk) begin : compare_rsp
        mem_rsp_t exp;
        if (rst_n && rsp_valid && check_en) begin
            assert (exp_q.size() > 0)
                else abort_run($sformatf("error at %0t: response with no request pending", $time));
            exp = exp_q.pop_front();
            assert (rsp.op == exp.op)
                else abort_run($sformatf("error at %0t: op %s, expected %s",
                                         $time, rsp.op.name(), exp.op.name()));
            if (exp.op == op_load) begin
                assert (rsp.rdata == exp.rdata)
                    else abort_run($sformatf("error at %0t: rdata %h, expected %h",
                                             $time, rsp.rdata, exp.rdata));
            end
            rsp_count++;
        end
    end

    always @(negedge clk) begin : watch_props
        assert (i_dut.i_sram.i_props.fail_count == 0)
            else abort_run("a bound AXI-lite assertion failed");
    end

    initial begin
        int unsigned seed_out;
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        check_en = 1'b1;
        rsp_count = 0;
        seed_out = $urandom(32'ha4b7a284);
        apply_reset();

        // quiet outputs and a cleared array after reset
        repeat (5) begin
            @(negedge clk);
            assert (!rsp_valid && !overflow)
                else abort_run($sformatf("error at %0t: rsp_valid or overflow high after reset",
                                         $time));
        end
        repeat (4) send_req(op_load, $urandom, '0, '0);
        wait_drain();

        send_req(op_store, 32'h0000_0040, 32'hdead_beef, 4'hf);
        send_req(op_load, 32'h0000_0040, '0, '0);
        wait_drain();

        // partial strobes and aliasing above 1 KiB
        send_req(op_store, 32'h0000_0080, 32'h1122_3344, 4'hf);
        send_req(op_store, 32'h0000_0080, 32'haabb_ccdd, 4'b0101);
        send_req(op_load, 32'h0000_0080, '0, '0);
        send_req(op_store, 32'h0000_0481, 32'h5566_7788, 4'b1100);
        send_req(op_load, 32'h0000_0080, '0, '0);
        send_req(op_store, 32'h0000_0c90, 32'h0000_ee00, 4'b0010);
        send_req(op_load, 32'h0000_0090, '0, '0);
        send_req(op_load, 32'hffff_fc90, '0, '0);
        wait_drain();

        for (int n = 0; n < 300; n++) begin
            op = ($urandom_range(1, 0) == 1) ? op_store : op_load;
            addr = $urandom & 32'h0000_3fff;  // 16 KiB folds onto 1 KiB
            wdata = (op == op_store) ? $urandom : '0;
            wstrb = (op == op_store) ? 4'($urandom) : '0;
            send_req(op, addr, wdata, wstrb);
        end
        wait_drain();
        @(negedge clk);
        assert (!overflow)
            else abort_run($sformatf("error at %0t: overflow set during spaced traffic", $time));

        send_req(op_store, 32'h0000_0040, 32'h0bad_cafe, 4'hf);  // wiped by the next reset
        wait_drain();

        // back-to-back burst with untracked responses
        check_en = 1'b0;
        for (int n = 0; n < 16; n++) begin
            @(posedge clk);
            #1;
            req.op = op_load;
            req.addr = 32'(n * 4);
            req.wdata = '0;
            req.wstrb = '0;
            req_valid = 1'b1;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        repeat (60) begin
            @(negedge clk);
            assert (overflow)
                else abort_run($sformatf("error at %0t: overflow low after burst", $time));
        end
        apply_reset();
        check_en = 1'b1;
        @(negedge clk);
        assert (!overflow)
            else abort_run($sformatf("error at %0t: overflow still set after reset", $time));
        send_req(op_load, 32'h0000_0040, '0, '0);  // array cleared again
        wait_drain();

        $display("checked %0d responses", rsp_count);
        if (i_dut.i_sram.i_props.fail_count != 0) begin
            abort_run("the bound AXI-lite assertions reported failures");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/mem_subsys_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_props import mem_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input axil_m2s_t axil_m2s,
    input axil_s2m_t axil_s2m
);

    int unsigned fail_count;

    initial fail_count = 0;

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_m2s.arvalid && !axil_s2m.arready
            |=> axil_m2s.arvalid && $stable(axil_m2s.araddr))
    else begin
        $error("arvalid or araddr changed before arready");
        fail_count = fail_count + 1;
    end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_m2s.awvalid && !axil_s2m.awready
            |=> axil_m2s.awvalid && $stable(axil_m2s.awaddr))
    else begin
        $error("awvalid or awaddr changed before awready");
        fail_count = fail_count + 1;
    end

    // one response channel at a time
    rb_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(axil_s2m.rvalid && axil_s2m.bvalid))
    else begin
        $error("rvalid and bvalid high together");
        fail_count = fail_count + 1;
    end

    r_drop: assert property (@(posedge clk) disable iff (!rst_n)
        axil_s2m.rvalid && axil_m2s.rready |=> !axil_s2m.rvalid)
    else begin
        $error("rvalid still high after the R transfer");
        fail_count = fail_count + 1;
    end

endmodule

bind axil_sram mem_subsys_props i_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_m2s (axil_m2s),
    .axil_s2m (axil_s2m)
);

`default_nettype wire

// File: hw/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  mem_req_t req,
    output logic     rsp_valid,
    output mem_rsp_t rsp,
    output logic     overflow
);

    logic      q_empty;
    mem_req_t  q_head;
    logic      pop;
    axil_m2s_t axil_m2s;
    axil_s2m_t axil_s2m;

    req_queue i_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (req_valid),
        .push_req (req),
        .pop      (pop),
        .head     (q_head),
        .empty    (q_empty),
        .overflow (overflow)
    );

    // one request in flight at a time
    lsu_axil_master i_lsu (
        .clk       (clk),
        .rst_n     (rst_n),
        .q_empty   (q_empty),
        .q_head    (q_head),
        .pop       (pop),
        .axil_m2s  (axil_m2s),
        .axil_s2m  (axil_s2m),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    axil_sram i_sram (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_m2s (axil_m2s),
        .axil_s2m (axil_s2m)
    );

endmodule

`default_nettype wire

// File: hw/axil_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axil_sram import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  axil_m2s_t axil_m2s,
    output axil_s2m_t axil_s2m
);

    sram_state_e           state;
    sram_state_e           next_state;
    logic [addr_w-1:0]     addr_q;
    logic [data_w-1:0]     wdata_q;
    logic [strb_w-1:0]     wstrb_q;
    logic                  w_got;     // W beat already taken
    logic [data_w-1:0]     rdata_q;
    logic [data_w-1:0]     mem [mem_words];
    logic [mem_idx_w-1:0]  idx;
    logic [lfsr_w-1:0]     lfsr;      // service delay
    logic [lfsr_w-1:0]     wait_cnt;
    logic                  sram_ack;
    logic                  match;
    logic                  ar_hs;
    logic                  aw_hs;
    logic                  w_hs;
    logic                  rsp_hs;

    assign idx   = addr_q[mem_idx_w+1:2];  // wraps modulo array size
    assign match = (wait_cnt == lfsr) && !sram_ack;

    always_comb begin
        axil_s2m.arready = state == st_idle;
        axil_s2m.awready = state == st_idle;
        axil_s2m.wready  = (state == st_idle) || (state == st_awrite);
        axil_s2m.rdata   = rdata_q;
        axil_s2m.rresp   = resp_okay;
        axil_s2m.rvalid  = (state == st_read) && sram_ack;
        axil_s2m.bresp   = resp_okay;
        axil_s2m.bvalid  = (state == st_write) && sram_ack;
    end

    assign ar_hs  = axil_m2s.arvalid && axil_s2m.arready;
    assign aw_hs  = axil_m2s.awvalid && axil_s2m.awready;
    assign w_hs   = axil_m2s.wvalid && axil_s2m.wready;
    assign rsp_hs = (axil_s2m.rvalid && axil_m2s.rready)
                 || (axil_s2m.bvalid && axil_m2s.bready);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (ar_hs)
                    next_state = st_read;
                else if (aw_hs)
                    next_state = st_awrite;
            end
            st_read: begin
                if (rsp_hs)
                    next_state = st_idle;
            end
            st_awrite: begin
                if (w_got || w_hs)
                    next_state = st_write;
            end
            st_write: begin
                if (rsp_hs)
                    next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            w_got    <= 1'b0;
            sram_ack <= 1'b0;
            wait_cnt <= '0;
            lfsr     <= lfsr_seed;
            rdata_q  <= nop_word;
        end else begin
            state <= next_state;
            if (state == st_write)
                w_got <= 1'b0;
            else if (w_hs)
                w_got <= 1'b1;  // w may come with aw in idle
            case (state)
                st_idle: begin
                    wait_cnt <= '0;
                    sram_ack <= 1'b0;
                    lfsr     <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
                end
                st_read, st_write: begin
                    if (sram_ack) begin
                        if (rsp_hs)
                            sram_ack <= 1'b0;  // hold valid until accepted
                    end else if (match) begin
                        sram_ack <= 1'b1;
                        wait_cnt <= '0;
                        if (state == st_read)
                            rdata_q <= mem[idx];
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: begin
                    wait_cnt <= '0;
                    sram_ack <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs)
            addr_q <= axil_m2s.araddr;
        else if (aw_hs)
            addr_q <= axil_m2s.awaddr;
        if (w_hs) begin
            wdata_q <= axil_m2s.wdata;
            wstrb_q <= axil_m2s.wstrb;
        end
    end

    // byte merge lands with bvalid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_words; i++)
                mem[i] <= '0;
        end else if ((state == st_write) && match) begin
            for (int b = 0; b < strb_w; b++) begin
                if (wstrb_q[b])
                    mem[idx][b*8 +: 8] <= wdata_q[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/lsu_axil_master.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_axil_master import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      q_empty,
    input  mem_req_t  q_head,
    output logic      pop,
    output axil_m2s_t axil_m2s,
    input  axil_s2m_t axil_s2m,
    output logic      rsp_valid,
    output mem_rsp_t  rsp
);

    lsu_state_e state;
    lsu_state_e next_state;
    mem_req_t   req_q;     // request in flight
    logic       aw_done;
    logic       w_done;
    logic       aw_hs;
    logic       w_hs;
    logic       ar_hs;
    logic       r_hs;
    logic       b_hs;

    assign ar_hs = axil_m2s.arvalid && axil_s2m.arready;
    assign aw_hs = axil_m2s.awvalid && axil_s2m.awready;
    assign w_hs  = axil_m2s.wvalid && axil_s2m.wready;
    assign r_hs  = (state == ls_r) && axil_s2m.rvalid && axil_m2s.rready;
    assign b_hs  = (state == ls_b) && axil_s2m.bvalid && axil_m2s.bready;

    assign pop = (state == ls_idle) && !q_empty;

    always_comb begin
        axil_m2s.araddr  = req_q.addr;
        axil_m2s.arvalid = state == ls_ar;
        axil_m2s.awaddr  = req_q.addr;
        axil_m2s.awvalid = (state == ls_aw_w) && !aw_done;
        axil_m2s.wdata   = req_q.wdata;
        axil_m2s.wstrb   = req_q.wstrb;
        axil_m2s.wvalid  = (state == ls_aw_w) && !w_done;
        axil_m2s.rready  = 1'b1;  // response side never stalls
        axil_m2s.bready  = 1'b1;
    end

    // response strobe in the R or B handshake cycle
    assign rsp_valid = r_hs || b_hs;
    assign rsp.op    = req_q.op;
    assign rsp.rdata = (req_q.op == op_load) ? axil_s2m.rdata : '0;

    always_comb begin
        next_state = state;
        case (state)
            ls_idle: begin
                if (!q_empty)
                    next_state = (q_head.op == op_load) ? ls_ar : ls_aw_w;
            end
            ls_ar: begin
                if (ar_hs)
                    next_state = ls_r;
            end
            ls_r: begin
                if (r_hs)
                    next_state = ls_idle;
            end
            ls_aw_w: begin
                // aw and w may finish in either order
                if ((aw_done || aw_hs) && (w_done || w_hs))
                    next_state = ls_b;
            end
            ls_b: begin
                if (b_hs)
                    next_state = ls_idle;
            end
            default: next_state = ls_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ls_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ls_aw_w) begin
                if (aw_hs)
                    aw_done <= 1'b1;
                if (w_hs)
                    w_done <= 1'b1;
            end else begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            req_q <= q_head;
    end

endmodule

`default_nettype wire

// File: hw/req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module req_queue import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  mem_req_t push_req,
    input  logic     pop,
    output mem_req_t head,
    output logic     empty,
    output logic     overflow
);

    mem_req_t               slots [queue_depth];
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_ptr_w:0]   count;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign full    = count == (queue_ptr_w + 1)'(queue_depth);
    assign empty   = count == '0;
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);  // a pop frees the slot this cycle
    assign head    = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !do_push)
                overflow <= 1'b1;  // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            slots[wr_ptr] <= push_req;
    end

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;
    localparam int resp_w = 2;

    localparam int mem_words = 256;
    localparam int mem_idx_w = $clog2(mem_words);   // word index is addr[9:2]
    localparam int queue_depth = 8;
    localparam int queue_ptr_w = $clog2(queue_depth);

    localparam int lfsr_w = 3;
    localparam logic [lfsr_w-1:0] lfsr_seed = 3'd1;  // must never be zero
    localparam logic [data_w-1:0] nop_word = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [resp_w-1:0] resp_okay = 2'b00;

    typedef enum logic {
        op_load,
        op_store
    } mem_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_awrite,
        st_write
    } sram_state_e;

    typedef enum logic [2:0] {
        ls_idle,
        ls_ar,
        ls_r,
        ls_aw_w,
        ls_b
    } lsu_state_e;

    typedef struct packed {
        mem_op_e               op;
        logic [addr_w-1:0]     addr;
        logic [data_w-1:0]     wdata;
        logic [strb_w-1:0]     wstrb;
    } mem_req_t;

    typedef struct packed {
        mem_op_e               op;
        logic [data_w-1:0]     rdata;
    } mem_rsp_t;

    // master to slave
    typedef struct packed {
        logic [addr_w-1:0]     araddr;
        logic                  arvalid;
        logic [addr_w-1:0]     awaddr;
        logic                  awvalid;
        logic [data_w-1:0]     wdata;
        logic [strb_w-1:0]     wstrb;
        logic                  wvalid;
        logic                  rready;
        logic                  bready;
    } axil_m2s_t;

    // slave to master
    typedef struct packed {
        logic                  arready;
        logic                  awready;
        logic                  wready;
        logic [data_w-1:0]     rdata;
        logic [resp_w-1:0]     rresp;
        logic                  rvalid;
        logic [resp_w-1:0]     bresp;
        logic                  bvalid;
    } axil_s2m_t;

endpackage

`default_nettype wire
